//--- hdl/frame_measure.sv
`timescale 1ns/1ps

module frame_measure
	import video_pkg::*;
(
	input  logic                 i_clk,
	input  logic                 i_reset,
	input  video_out_t           i_video,
	output logic                 o_locked,
	output logic [POS_WIDTH-1:0] o_width,
	output logic [POS_WIDTH-1:0] o_height
);

	logic                 prev_hsync_n;
	logic                 prev_vsync_n;
	logic                 h_fall;
	logic                 v_fall;
	logic                 active;
	logic                 line_end;
	logic [POS_WIDTH-1:0] pix_cnt;
	logic [POS_WIDTH-1:0] line_cnt;
	logic [POS_WIDTH-1:0] line_width;
	logic [POS_WIDTH-1:0] meas_width;
	logic [POS_WIDTH-1:0] meas_height;

	assign h_fall = prev_hsync_n & ~i_video.timing.hsync_n;
	assign v_fall = prev_vsync_n & ~i_video.timing.vsync_n;
	assign active = ~i_video.timing.hblank & ~i_video.timing.vblank;

	// A line counts only if it carried active pixels
	assign line_end = h_fall && (pix_cnt != '0);

	// Include a line that closes on the same edge as vsync
	assign meas_width  = line_end ? pix_cnt : line_width;
	assign meas_height = line_cnt + POS_WIDTH'(line_end);

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			prev_hsync_n <= 1'b1;
			prev_vsync_n <= 1'b1;
			pix_cnt      <= '0;
			line_cnt     <= '0;
			line_width   <= '0;
			o_locked     <= 1'b0;
			o_width      <= '0;
			o_height     <= '0;
		end else begin
			prev_hsync_n <= i_video.timing.hsync_n;
			prev_vsync_n <= i_video.timing.vsync_n;

			if (h_fall) begin
				pix_cnt <= '0;
			end else if (active) begin
				pix_cnt <= pix_cnt + 1'b1;
			end

			if (v_fall) begin
				line_cnt   <= '0;
				line_width <= '0;
				o_width    <= meas_width;
				o_height   <= meas_height;
				// Lock needs the same nonzero size on two frames in a row
				o_locked   <= (meas_width == o_width) && (meas_height == o_height) &&
					(meas_width != '0) && (meas_height != '0);
			end else if (line_end) begin
				line_cnt   <= meas_height;
				line_width <= pix_cnt;
			end
		end
	end

endmodule

//--- hdl/raster_sync_gen.sv
`timescale 1ns/1ps

module raster_sync_gen
	import video_pkg::*;
(
	input  logic  i_clk,
	input  logic  i_reset,
	output sync_t o_sync
);

	logic [POS_WIDTH-1:0] h_cnt;
	logic [POS_WIDTH-1:0] v_cnt;
	logic                 h_wrap;
	logic                 v_wrap;

	assign h_wrap = (h_cnt == POS_WIDTH'(H_TOTAL - 1));
	assign v_wrap = (v_cnt == POS_WIDTH'(V_TOTAL - 1));

	// Pixel and line counters
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else begin
			if (h_wrap) begin
				h_cnt <= '0;
				// Line advances as the pixel count returns to 0
				if (v_wrap) begin
					v_cnt <= '0;
				end else begin
					v_cnt <= v_cnt + 1'b1;
				end
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	// Registered sync pulses, low during the sync regions
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_sync.hsync_n <= 1'b1;
			o_sync.vsync_n <= 1'b1;
		end else begin
			o_sync.hsync_n <= (h_cnt >= POS_WIDTH'(H_SYNC));
			o_sync.vsync_n <= (v_cnt >= POS_WIDTH'(V_SYNC));
		end
	end

endmodule

//--- hdl/sync_to_blanking.sv
`timescale 1ns/1ps

module sync_to_blanking
	import video_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_reset,
	input  sync_t       i_sync,
	output timing_t     o_timing,
	output raster_pos_t o_pos
);

	logic [POS_WIDTH-1:0] h_cnt;
	logic [POS_WIDTH-1:0] v_cnt;
	logic [POS_WIDTH-1:0] h_next;
	logic [POS_WIDTH-1:0] v_next;
	logic                 h_seen;
	logic                 v_seen;
	logic                 h_fall;
	logic                 v_fall;
	logic                 h_active;
	logic                 v_active;

	// Registered syncs double as the previous sample for edge detection
	assign h_fall = o_timing.hsync_n & ~i_sync.hsync_n;
	assign v_fall = o_timing.vsync_n & ~i_sync.vsync_n;

	// Counts saturate so a missing sync never wraps back into active
	always_comb begin
		if (h_fall) begin
			h_next = '0;
		end else if (h_cnt != '1) begin
			h_next = h_cnt + 1'b1;
		end else begin
			h_next = h_cnt;
		end

		if (v_fall) begin
			v_next = '0;
		end else if (h_fall && v_cnt != '1) begin
			v_next = v_cnt + 1'b1;
		end else begin
			v_next = v_cnt;
		end

		h_active = (h_seen | h_fall) &&
			(h_next >= POS_WIDTH'(H_SYNC + H_BACK)) &&
			(h_next < POS_WIDTH'(H_SYNC + H_BACK + H_ACTIVE));
		v_active = (h_seen | h_fall) && (v_seen | v_fall) &&
			(v_next >= POS_WIDTH'(V_SYNC + V_BACK)) &&
			(v_next < POS_WIDTH'(V_SYNC + V_BACK + V_ACTIVE));
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			h_cnt    <= '0;
			v_cnt    <= '0;
			h_seen   <= 1'b0;
			v_seen   <= 1'b0;
			o_timing <= '{hsync_n: 1'b1, vsync_n: 1'b1, hblank: 1'b1, vblank: 1'b1};
			o_pos    <= '0;
		end else begin
			h_cnt            <= h_next;
			v_cnt            <= v_next;
			h_seen           <= h_seen | h_fall;
			v_seen           <= v_seen | v_fall;
			o_timing.hsync_n <= i_sync.hsync_n;
			o_timing.vsync_n <= i_sync.vsync_n;
			o_timing.hblank  <= ~h_active;
			o_timing.vblank  <= ~v_active;
			o_pos.x          <= h_active ? h_next - POS_WIDTH'(H_SYNC + H_BACK) : '0;
			o_pos.y          <= v_active ? v_next - POS_WIDTH'(V_SYNC + V_BACK) : '0;
		end
	end

endmodule

//--- hdl/tile_clut_pixel.sv
`timescale 1ns/1ps

module tile_clut_pixel
	import video_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_reset,
	input  timing_t     i_timing,
	input  raster_pos_t i_pos,
	input  clut_write_t i_clut_wr,
	output video_out_t  o_video
);

	rgb_t       clut [16];
	logic [3:0] pal_idx;
	logic       blank;
	rgb_t       pal_colour;

	////////////////////////////////////////////////////////////////////////////
	// Palette index from tile coordinates
	////////////////////////////////////////////////////////////////////////////

	// Checker of tile column against tile row
	assign pal_idx    = 4'((i_pos.x >> TILE_SHIFT) ^ (i_pos.y >> TILE_SHIFT));
	assign blank      = i_timing.hblank | i_timing.vblank;
	assign pal_colour = clut[pal_idx];

	// Host write port, new entry visible from the next pixel on
	always_ff @(posedge i_clk) begin
		if (i_clut_wr.we) begin
			clut[i_clut_wr.addr] <= i_clut_wr.colour;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_video.timing <= '{hsync_n: 1'b1, vsync_n: 1'b1, hblank: 1'b1, vblank: 1'b1};
			o_video.rgb    <= '0;
		end else begin
			// Timing delayed with the colour keeps the sync spacing intact
			o_video.timing <= i_timing;
			if (blank) begin
				o_video.rgb <= '0;
			end else begin
				o_video.rgb <= pal_colour;
			end
		end
	end

endmodule

//--- hdl/video_out_top.sv
`timescale 1ns/1ps

module video_out_top
	import video_pkg::*;
(
	input  logic                 i_clk,
	input  logic                 i_reset,
	input  clut_write_t          i_clut_wr,
	output video_out_t           o_video,
	output logic                 o_locked,
	output logic [POS_WIDTH-1:0] o_width,
	output logic [POS_WIDTH-1:0] o_height
);

	sync_t       raster_sync;
	timing_t     raster_timing;
	raster_pos_t raster_pos;

	raster_sync_gen u_sync_gen (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.o_sync  (raster_sync)
	);

	// Blanking rebuilt from the sync pulses only
	sync_to_blanking u_blanking (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_sync   (raster_sync),
		.o_timing (raster_timing),
		.o_pos    (raster_pos)
	);

	tile_clut_pixel u_pixel (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_timing  (raster_timing),
		.i_pos     (raster_pos),
		.i_clut_wr (i_clut_wr),
		.o_video   (o_video)
	);

	// Watches the final output stream
	frame_measure u_measure (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_video  (o_video),
		.o_locked (o_locked),
		.o_width  (o_width),
		.o_height (o_height)
	);

endmodule

//--- hdl/video_pkg.sv
package video_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Panel geometry
	////////////////////////////////////////////////////////////////////////////

	localparam int COMPONENT_DEPTH = 4;

	// Horizontal regions in pixels, sync first
	localparam int H_SYNC   = 4;
	localparam int H_BACK   = 6;
	localparam int H_ACTIVE = 32;
	localparam int H_FRONT  = 6;
	localparam int H_TOTAL  = H_SYNC + H_BACK + H_ACTIVE + H_FRONT;

	// Vertical regions in lines
	localparam int V_SYNC   = 2;
	localparam int V_BACK   = 3;
	localparam int V_ACTIVE = 24;
	localparam int V_FRONT  = 3;
	localparam int V_TOTAL  = V_SYNC + V_BACK + V_ACTIVE + V_FRONT;

	// 4x4 pixel tiles
	localparam int TILE_SHIFT = 2;
	localparam int POS_WIDTH  = 12;

	////////////////////////////////////////////////////////////////////////////
	// Bundles
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [COMPONENT_DEPTH-1:0] red;
		logic [COMPONENT_DEPTH-1:0] green;
		logic [COMPONENT_DEPTH-1:0] blue;
	} rgb_t;

	typedef struct packed {
		logic hsync_n;
		logic vsync_n;
	} sync_t;

	typedef struct packed {
		logic hsync_n;
		logic vsync_n;
		logic hblank;
		logic vblank;
	} timing_t;

	// Position inside the active area
	typedef struct packed {
		logic [POS_WIDTH-1:0] x;
		logic [POS_WIDTH-1:0] y;
	} raster_pos_t;

	typedef struct packed {
		logic       we;
		logic [3:0] addr;
		rgb_t       colour;
	} clut_write_t;

	typedef struct packed {
		timing_t timing;
		rgb_t    rgb;
	} video_out_t;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the video output testbench with Verilator and runs it.
# Exits nonzero if the build fails or the simulation reports failure.

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_name=video_out_sim

if ! verilator --binary --timing -f vlog.f --top-module video_out_tb \
	-Mdir "$build_dir" -o "$sim_name"; then
	echo "Verilator build failed"
	exit 1
fi

"./$build_dir/$sim_name"
status=$?

if [ "$status" -ne 0 ]; then
	echo "Simulation ended with status $status"
	exit "$status"
fi

echo "Simulation ended with status 0"
exit 0

//--- verif/video_out_tb.sv
`timescale 1ns/1ps

module video_out_tb
	import video_pkg::*;
();

	logic                 clk;
	logic                 reset;
	clut_write_t          clut_wr;
	video_out_t           video;
	logic                 locked;
	logic [POS_WIDTH-1:0] width;
	logic [POS_WIDTH-1:0] height;

	rgb_t        clut_model [16];
	logic [31:0] lcg_state;
	int          checks_done;
	logic        rgb_check_en;
	logic [3:0]  watch_idx;
	int          watch_hits;
	event        frame_start;

	// Raster tracking rebuilt from the output syncs
	logic prev_hs;
	logic prev_vs;
	logic h_seen;
	logic v_seen;
	int   h;
	int   v;
	int   act_pix;
	int   act_lines;

	video_out_top uut (
		.i_clk     (clk),
		.i_reset   (reset),
		.i_clut_wr (clut_wr),
		.o_video   (video),
		.o_locked  (locked),
		.o_width   (width),
		.o_height  (height)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Twelve frames is well past the length of all tests
	initial begin
		#(12 * H_TOTAL * V_TOTAL * 40);
		$display("Simulation timed out at %0t before the tests finished", $time);
		end_in_failure();
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers and compare tasks
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic end_in_failure();
		$display("CHECKS FAILED");
		$fatal(1, "run stopped after a failure");
	endtask

	task automatic check_rgb(input rgb_t got, input rgb_t exp, input string msg);
		checks_done++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
			end_in_failure();
		end
	endtask

	task automatic check_timing(input timing_t got, input timing_t exp, input string msg);
		checks_done++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, msg, got, exp);
			end_in_failure();
		end
	endtask

	task automatic check_size(input logic [POS_WIDTH-1:0] got,
		input logic [POS_WIDTH-1:0] exp, input string msg);
		checks_done++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, msg, got, exp);
			end_in_failure();
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string msg);
		checks_done++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, msg, got, exp);
			end_in_failure();
		end
	endtask

	// Called on a falling edge, returns on the next one
	task automatic write_clut(input logic [3:0] addr, input rgb_t colour);
		clut_wr.we     = 1'b1;
		clut_wr.addr   = addr;
		clut_wr.colour = colour;
		clut_model[addr] = colour;
		@(negedge clk);
		clut_wr.we = 1'b0;
	endtask

	task automatic expect_idle_outputs(input string when);
		check_timing(video.timing, timing_t'(4'b1111), {"timing ", when});
		check_rgb(video.rgb, '0, {"rgb ", when});
		check_bit(locked, 1'b0, {"locked ", when});
		check_size(width, '0, {"width ", when});
		check_size(height, '0, {"height ", when});
	endtask

	task automatic expect_lock(input string when);
		check_bit(locked, 1'b1, {"locked ", when});
		check_size(width, POS_WIDTH'(H_ACTIVE), {"width ", when});
		check_size(height, POS_WIDTH'(V_ACTIVE), {"height ", when});
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Output monitor
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin : monitor
		timing_t    exp_timing;
		logic       hs_fall;
		logic       vs_fall;
		int         x;
		int         y;
		logic [3:0] idx;

		if (reset) begin
			prev_hs   = 1'b1;
			prev_vs   = 1'b1;
			h_seen    = 1'b0;
			v_seen    = 1'b0;
			h         = 0;
			v         = 0;
			act_pix   = 0;
			act_lines = 0;
		end else begin
			hs_fall = prev_hs & ~video.timing.hsync_n;
			vs_fall = prev_vs & ~video.timing.vsync_n;
			prev_hs = video.timing.hsync_n;
			prev_vs = video.timing.vsync_n;
			if (vs_fall) begin
				check_bit(hs_fall, 1'b1, "hsync edge alongside vsync edge");
			end
			if (hs_fall) begin
				// Close the line that just ended
				if (h_seen) begin
					check_size(POS_WIDTH'(h + 1), POS_WIDTH'(H_TOTAL), "line period");
				end
				if (act_pix != 0) begin
					check_size(POS_WIDTH'(act_pix), POS_WIDTH'(H_ACTIVE), "active pixels per line");
					act_lines++;
				end
				act_pix = 0;
				h       = 0;
				h_seen  = 1'b1;
				if (vs_fall) begin
					if (v_seen) begin
						check_size(POS_WIDTH'(v + 1), POS_WIDTH'(V_TOTAL), "frame period");
						check_size(POS_WIDTH'(act_lines), POS_WIDTH'(V_ACTIVE), "active lines");
					end
					act_lines = 0;
					v         = 0;
					v_seen    = 1'b1;
				end else begin
					v++;
				end
			end else if (h_seen) begin
				h++;
			end

			// Active run length as the output flags show it
			if (!video.timing.hblank && !video.timing.vblank) begin
				act_pix++;
			end

			exp_timing.hsync_n = !h_seen || (h >= H_SYNC);
			exp_timing.vsync_n = !v_seen || (v >= V_SYNC);
			exp_timing.hblank  = !(h_seen && h >= H_SYNC + H_BACK &&
				h < H_SYNC + H_BACK + H_ACTIVE);
			exp_timing.vblank  = !(h_seen && v_seen && v >= V_SYNC + V_BACK &&
				v < V_SYNC + V_BACK + V_ACTIVE);
			check_timing(video.timing, exp_timing, "output timing");

			if (exp_timing.hblank || exp_timing.vblank) begin
				check_rgb(video.rgb, '0, "blanked pixel");
			end else begin
				x   = h - (H_SYNC + H_BACK);
				y   = v - (V_SYNC + V_BACK);
				idx = 4'((x >> TILE_SHIFT) ^ (y >> TILE_SHIFT));
				if (idx == watch_idx && video.rgb === clut_model[watch_idx]) begin
					watch_hits++;
				end
				if (rgb_check_en) begin
					check_rgb(video.rgb, clut_model[idx], "active pixel colour");
				end
			end

			if (hs_fall && vs_fall) begin
				-> frame_start;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic reset_state();
		repeat (2) begin
			@(negedge clk);
			expect_idle_outputs("during reset");
		end
		reset = 1'b0;
		@(negedge clk);
		expect_idle_outputs("after reset");
	endtask

	// Load the whole CLUT at the top of a frame, then check the next one
	task automatic palette_frame();
		int i;
		@(frame_start);
		for (i = 0; i < 16; i++) begin
			lcg_state = lcg_next(lcg_state);
			write_clut(4'(i), rgb_t'(lcg_state[27:16]));
		end
		rgb_check_en = 1'b1;
		@(frame_start);
	endtask

	task automatic clut_rewrite();
		rgb_t colour;
		lcg_state = lcg_next(lcg_state);
		colour    = rgb_t'(lcg_state[27:16]);
		if (colour == clut_model[5]) begin
			colour = rgb_t'(colour ^ 12'h5a5);
		end
		watch_idx  = 4'd5;
		watch_hits = 0;
		write_clut(watch_idx, colour);
		@(frame_start);
		check_bit(watch_hits != 0, 1'b1, "rewritten entry shown on screen");
	endtask

	// Measurements land one cycle after the output vsync edge
	task automatic frame_lock();
		@(frame_start);
		@(negedge clk);
		expect_lock("after third frame");
		repeat (2 * H_TOTAL * V_TOTAL) begin
			@(negedge clk);
			expect_lock("in later frames");
		end
	endtask

	initial begin
		reset        = 1'b1;
		clut_wr      = '0;
		lcg_state    = 32'h1014d3ab;
		checks_done  = 0;
		rgb_check_en = 1'b0;
		watch_idx    = 4'd0;
		watch_hits   = 0;

		reset_state();
		palette_frame();
		clut_rewrite();
		frame_lock();

		if (checks_done > 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			$display("No checks were run");
			end_in_failure();
		end
	end

endmodule

//--- vlog.f
hdl/video_pkg.sv
hdl/raster_sync_gen.sv
hdl/sync_to_blanking.sv
hdl/tile_clut_pixel.sv
hdl/frame_measure.sv
hdl/video_out_top.sv
verif/video_out_tb.sv
